/* hw/sha256_cfg.svh */
`ifndef SHA256_CFG_SVH
`define SHA256_CFG_SVH

// width of one message or hash word
`define SHA_WORD_W 32

// compression rounds per 512-bit block
`define SHA_ROUNDS 64

// message words taken from the input per block
`define SHA_BLOCK_WORDS 16

// words in the chaining value
`define SHA_HASH_WORDS 8

`endif

/* hw/sha256_pkg.sv */
`default_nettype none

`include "sha256_cfg.svh"

package sha256_pkg;

   // one 32-bit word
   typedef logic [`SHA_WORD_W-1:0] word_t;

   // executing round, 0 to 63
   typedef logic [$clog2(`SHA_ROUNDS)-1:0] round_t;

   // eight hash words, index 0 is H0
   typedef word_t [`SHA_HASH_WORDS-1:0] digest_t;

   // rotate right, n is 1 to 31
   function automatic word_t rotr(input word_t x, input int unsigned n);
      return (x >> n) | (x << (`SHA_WORD_W - n));
   endfunction

   // logical shift right
   function automatic word_t shr(input word_t x, input int unsigned n);
      return x >> n;
   endfunction

endpackage

`default_nettype wire

/* hw/sha256_round_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface sha256_round_if;
   import sha256_pkg::*;

   // start of a block
   logic load;
   // one round this cycle
   logic step;
   round_t round;
   // add working variables into chaining value
   logic finish;

   modport ctrl (
      output load,
      output step,
      output round,
      output finish
   );

   modport sched (input load, input step, input round);

   modport datapath (input load, input step);

   modport acc (input load, input finish);

endinterface

`default_nettype wire

/* hw/sha256_k_rom.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sha256_cfg.svh"

module sha256_k_rom (
   input  sha256_pkg::round_t round,
   output sha256_pkg::word_t  k
);
   import sha256_pkg::*;

   // first 32 bits of the fractional parts of the cube roots of the first 64 primes
   localparam word_t K_TABLE [`SHA_ROUNDS] = '{
      32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
      32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
      32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
      32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
      32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
      32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
      32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
      32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
      32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
      32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
      32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
      32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
      32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
      32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
      32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
      32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
   };

   // combinational lookup, ready in the round's own cycle
   assign k = K_TABLE[round];

endmodule

`default_nettype wire

/* hw/sha256_msg_sched.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sha256_cfg.svh"

module sha256_msg_sched (
   input  logic                 clk,
   input  logic                 rst,
   sha256_round_if.sched        rif,
   input  sha256_pkg::word_t    msg_word,
   output sha256_pkg::word_t    wt
);
   import sha256_pkg::*;

   localparam int LAST = `SHA_BLOCK_WORDS - 1;

   // w[LAST] holds W[t-1], w[0] holds W[t-16]
   word_t w [`SHA_BLOCK_WORDS];
   word_t w_ext;

   function automatic word_t ssig0(input word_t x);
      return rotr(x, 7) ^ rotr(x, 18) ^ shr(x, 3);
   endfunction

   function automatic word_t ssig1(input word_t x);
      return rotr(x, 17) ^ rotr(x, 19) ^ shr(x, 10);
   endfunction

   // W[t] = s1(W[t-2]) + W[t-7] + s0(W[t-15]) + W[t-16]
   assign w_ext = ssig1(w[LAST-1]) + w[LAST-6] + ssig0(w[1]) + w[0];

   // first 16 rounds take the input word straight through
   assign wt = (rif.round < round_t'(`SHA_BLOCK_WORDS)) ? msg_word : w_ext;

   always_ff @(posedge clk) begin
      if (rif.load) begin
         for (int i = 0; i < `SHA_BLOCK_WORDS; i++) begin
            w[i] <= '0;
         end
      end else if (rif.step) begin
         for (int i = 0; i < LAST; i++) begin
            w[i] <= w[i+1];
         end
         w[LAST] <= wt;
      end
   end

   // a block never starts in a cycle that also runs a round
   load_step_excl: assert property (
      @(posedge clk) disable iff (rst) !(rif.load && rif.step)
   );

endmodule

`default_nettype wire

/* hw/sha256_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sha256_cfg.svh"

module sha256_ctrl (
   input  logic        clk,
   input  logic        rst,
   input  logic        start,
   input  logic        en,
   sha256_round_if.ctrl rif,
   output logic        busy,
   output logic        done
);
   import sha256_pkg::*;

   round_t round_r;
   logic   finish_r;
   logic   last_round;

   // start while busy is dropped
   assign rif.load   = start & ~busy;
   assign rif.step   = busy & en;
   assign rif.round  = round_r;
   assign rif.finish = finish_r;

   assign last_round = (round_r == round_t'(`SHA_ROUNDS - 1));

   always_ff @(posedge clk) begin
      if (rst) begin
         busy     <= 1'b0;
         round_r  <= '0;
         finish_r <= 1'b0;
         done     <= 1'b0;
      end else begin
         finish_r <= rif.step & last_round;
         // digest is updated on the finish edge, so done trails by one
         done     <= finish_r;
         if (rif.load) begin
            busy    <= 1'b1;
            round_r <= '0;
         end else if (rif.step) begin
            round_r <= round_r + 1'b1;
            if (last_round) begin
               busy <= 1'b0;
            end
         end
      end
   end

   // busy only drops on the edge that runs round 63
   busy_ends_at_last_round: assert property (
      @(posedge clk) disable iff (rst) $fell(busy) |-> rif.finish
   );

   // accumulate never overlaps a running round
   finish_step_excl: assert property (
      @(posedge clk) disable iff (rst) !(rif.finish && rif.step)
   );

endmodule

`default_nettype wire

/* hw/sha256_round.sv */
`timescale 1ns/1ps
`default_nettype none

module sha256_round (
   input  logic                 clk,
   input  logic                 rst,
   sha256_round_if.datapath     rif,
   input  sha256_pkg::digest_t  iv,
   input  sha256_pkg::word_t    wt,
   input  sha256_pkg::word_t    k,
   output sha256_pkg::digest_t  state
);
   import sha256_pkg::*;

   // working variables
   word_t a, b, c, d, e, f, g, h;

   word_t bsig0;
   word_t bsig1;
   word_t ch;
   word_t maj;
   word_t t1;
   word_t t2;

   assign bsig0 = rotr(a, 2) ^ rotr(a, 13) ^ rotr(a, 22);
   assign bsig1 = rotr(e, 6) ^ rotr(e, 11) ^ rotr(e, 25);

   // choose f or g by bits of e
   assign ch  = (e & f) ^ (~e & g);
   assign maj = (a & b) ^ (a & c) ^ (b & c);

   assign t1 = h + bsig1 + ch + k + wt;
   assign t2 = bsig0 + maj;

   always_ff @(posedge clk) begin
      if (rst) begin
         a <= '0;
         b <= '0;
         c <= '0;
         d <= '0;
         e <= '0;
         f <= '0;
         g <= '0;
         h <= '0;
      end else if (rif.load) begin
         a <= iv[0];
         b <= iv[1];
         c <= iv[2];
         d <= iv[3];
         e <= iv[4];
         f <= iv[5];
         g <= iv[6];
         h <= iv[7];
      end else if (rif.step) begin
         a <= t1 + t2;
         b <= a;
         c <= b;
         d <= c;
         e <= d + t1;
         f <= e;
         g <= f;
         h <= g;
      end
   end

   // a in word 0, h in word 7
   assign state = {h, g, f, e, d, c, b, a};

endmodule

`default_nettype wire

/* hw/sha256_digest.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sha256_cfg.svh"

module sha256_digest (
   input  logic                 clk,
   input  logic                 rst,
   sha256_round_if.acc          rif,
   input  sha256_pkg::digest_t  iv,
   input  sha256_pkg::digest_t  state,
   output sha256_pkg::digest_t  digest
);
   import sha256_pkg::*;

   digest_t hash_r;

   // a new block takes the chaining value from iv
   always_ff @(posedge clk) begin
      if (rst) begin
         hash_r <= '0;
      end else if (rif.load) begin
         hash_r <= iv;
      end else if (rif.finish) begin
         // each word adds mod 2^32 on its own
         for (int i = 0; i < `SHA_HASH_WORDS; i++) begin
            hash_r[i] <= hash_r[i] + state[i];
         end
      end
   end

   assign digest = hash_r;

endmodule

`default_nettype wire

/* hw/sha256_core.sv */
`timescale 1ns/1ps
`default_nettype none

module sha256_core (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 start,
   input  logic                 en,
   input  sha256_pkg::digest_t  iv,
   input  sha256_pkg::word_t    msg_word,
   output logic                 busy,
   output logic                 done,
   output sha256_pkg::digest_t  digest
);
   import sha256_pkg::*;

   word_t   wt;
   word_t   k;
   digest_t state;

   // round control shared by all units
   sha256_round_if rif ();

   sha256_ctrl i_ctrl (
      .clk   (clk),
      .rst   (rst),
      .start (start),
      .en    (en),
      .rif   (rif),
      .busy  (busy),
      .done  (done)
   );

   sha256_msg_sched i_msg_sched (
      .clk      (clk),
      .rst      (rst),
      .rif      (rif),
      .msg_word (msg_word),
      .wt       (wt)
   );

   sha256_k_rom i_k_rom (
      .round (rif.round),
      .k     (k)
   );

   sha256_round i_round (
      .clk   (clk),
      .rst   (rst),
      .rif   (rif),
      .iv    (iv),
      .wt    (wt),
      .k     (k),
      .state (state)
   );

   sha256_digest i_digest (
      .clk    (clk),
      .rst    (rst),
      .rif    (rif),
      .iv     (iv),
      .state  (state),
      .digest (digest)
   );

endmodule

`default_nettype wire

/* verif/tb_sha256_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sha256_cfg.svh"

module tb_sha256_core;
   import sha256_pkg::*;

   localparam int MAX_VEC = 8;
   localparam int NAME_W = 8 * 24;
   localparam int DONE_TIMEOUT = 400;
   // load edge, then one edge per round, then the finish edge
   localparam int DONE_EDGE = `SHA_ROUNDS + 1;
   localparam int VEC_WORDS = 2 * `SHA_HASH_WORDS + `SHA_BLOCK_WORDS;

   logic    clk;
   logic    rst;
   logic    start;
   logic    en;
   digest_t iv;
   word_t   msg_word;
   logic    busy;
   logic    done;
   digest_t digest;

   string   vec_name [MAX_VEC];
   digest_t vec_iv [MAX_VEC];
   word_t   vec_msg [MAX_VEC][`SHA_BLOCK_WORDS];
   digest_t vec_exp [MAX_VEC];
   int      n_vec;

   int pass_count;
   int fail_count;
   int seed;

   sha256_core i_sha256_core (
      .clk      (clk),
      .rst      (rst),
      .start    (start),
      .en       (en),
      .iv       (iv),
      .msg_word (msg_word),
      .busy     (busy),
      .done     (done),
      .digest   (digest)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #5 clk = ~clk;
      end
   end

   // inputs change 1 ns after the rising edge
   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic apply_reset();
      rst = 1'b1;
      start = 1'b0;
      en = 1'b0;
      repeat (10) next_cycle();
      rst = 1'b0;
   endtask

   task automatic check_digest(input string name, input digest_t exp, input digest_t act);
      if (act === exp) begin
         pass_count++;
         $display("%s: ok", name);
      end else begin
         fail_count++;
         $display("Error %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act === exp) begin
         pass_count++;
         $display("%s: ok", name);
      end else begin
         fail_count++;
         $display("Error %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   // packed token to string, dropping the leading null bytes
   function automatic string name_of(input logic [NAME_W-1:0] raw);
      string s;
      s = "";
      for (int b = NAME_W / 8 - 1; b >= 0; b--) begin
         if (raw[b*8 +: 8] != 8'h00) begin
            s = $sformatf("%s%c", s, raw[b*8 +: 8]);
         end
      end
      return s;
   endfunction

   task automatic load_vectors();
      int                fd;
      int                rc;
      logic [NAME_W-1:0] tok;
      logic [8*512-1:0]  rest;
      word_t             val;
      n_vec = 0;
      fd = $fopen("verif/sha256_vectors.txt", "r");
      if (fd == 0) begin
         $display("vector file verif/sha256_vectors.txt could not be opened");
         fail_count++;
         return;
      end
      while (n_vec < MAX_VEC) begin
         tok = '0;
         rc = $fscanf(fd, "%s", tok);
         if (rc != 1) begin
            break;
         end
         if (tok == NAME_W'("#")) begin
            // comment line, skip the rest
            rc = $fgets(rest, fd);
         end else begin
            vec_name[n_vec] = name_of(tok);
            for (int j = 0; j < VEC_WORDS; j++) begin
               rc = $fscanf(fd, "%h", val);
               if (rc != 1) begin
                  $display("vector %s is missing words", vec_name[n_vec]);
                  fail_count++;
               end
               if (j < `SHA_HASH_WORDS) begin
                  vec_iv[n_vec][j] = val;
               end else if (j < `SHA_HASH_WORDS + `SHA_BLOCK_WORDS) begin
                  vec_msg[n_vec][j - `SHA_HASH_WORDS] = val;
               end else begin
                  vec_exp[n_vec][j - `SHA_HASH_WORDS - `SHA_BLOCK_WORDS] = val;
               end
            end
            n_vec++;
         end
      end
      $fclose(fd);
      if (n_vec == 0) begin
         $display("vector file holds no tests");
         fail_count++;
      end
   endtask

   // one block from start to done, message words fed as rounds consume them
   task automatic run_block(input int idx, input bit gaps, input bit mid_start,
                            input bit fixed_timing, input string tag);
      int      cyc;
      int      cnt;
      int      done_cyc;
      int      tail;
      bit      extra_done;
      bit      step_next;
      digest_t got;
      cyc = 0;
      cnt = 0;
      done_cyc = -1;
      tail = mid_start ? 80 : 1;
      extra_done = 1'b0;
      got = '0;
      start = 1'b1;
      iv = vec_iv[idx];
      en = 1'b1;
      msg_word = vec_msg[idx][0];
      next_cycle();
      start = 1'b0;
      while (cyc < DONE_TIMEOUT + tail) begin
         if (done) begin
            if (done_cyc < 0) begin
               done_cyc = cyc;
               got = digest;
            end else begin
               extra_done = 1'b1;
            end
         end
         if (done_cyc >= 0 && cyc >= done_cyc + tail) begin
            break;
         end
         if (done_cyc < 0 && cyc >= DONE_TIMEOUT) begin
            break;
         end
         en = gaps ? (($random(seed) & 3) != 0) : 1'b1;
         msg_word = (cnt < `SHA_BLOCK_WORDS) ? vec_msg[idx][cnt] : '0;
         // second start lands while busy is high
         start = mid_start && (cyc == 20);
         step_next = busy & en;
         next_cycle();
         cyc++;
         if (step_next) begin
            cnt++;
         end
      end
      start = 1'b0;
      en = 1'b1;
      if (done_cyc < 0) begin
         $display("%s: done never arrived within %0d cycles", tag, DONE_TIMEOUT);
         fail_count++;
         apply_reset();
         return;
      end
      check_digest({tag, " digest"}, vec_exp[idx], got);
      check_flag({tag, " single done pulse"}, 1'b0, extra_done);
      if (fixed_timing) begin
         check_flag({tag, " done in cycle 66"}, 1'b1, done_cyc == DONE_EDGE);
      end
   endtask

   initial begin
      rst = 1'b1;
      start = 1'b0;
      en = 1'b0;
      iv = '0;
      msg_word = '0;
      pass_count = 0;
      fail_count = 0;
      seed = 32'hb4300191;
      load_vectors();
      apply_reset();

      check_flag("reset busy", 1'b0, busy);
      check_flag("reset done", 1'b0, done);
      check_digest("reset digest", '0, digest);

      // en held high, in file order so two_blk_2 follows two_blk_1
      for (int i = 0; i < n_vec; i++) begin
         run_block(i, 1'b0, 1'b0, 1'b1, vec_name[i]);
      end

      // random stalls on en
      for (int i = 0; i < n_vec; i++) begin
         run_block(i, 1'b1, 1'b0, 1'b0, {vec_name[i], " with en gaps"});
      end

      if (n_vec > 0) begin
         run_block(0, 1'b0, 1'b1, 1'b0, {vec_name[0], " with start while busy"});
      end

      $display("checks passed: %0d, failed: %0d", pass_count, fail_count);
      if (fail_count == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* src.f */
+incdir+hw
hw/sha256_pkg.sv
hw/sha256_round_if.sv
hw/sha256_k_rom.sv
hw/sha256_msg_sched.sv
hw/sha256_ctrl.sv
hw/sha256_round.sv
hw/sha256_digest.sv
hw/sha256_core.sv
verif/tb_sha256_core.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f src.f \
   --top-module tb_sha256_core -o tb_sha256_core \
   && ./obj_dir/tb_sha256_core > sim.log 2>&1 \
   || { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }

cat sim.log
grep -q "sim failed" sim.log && { echo "test run reported a failure"; exit 1; } \
   || echo "test run clean"
exit 0

/* verif/sha256_vectors.txt */
# name, iv words 0 to 7, message words 0 to 15, expected digest words 0 to 7 (all hex)
# two_blk_2 takes the digest of two_blk_1 as its iv
abc 6a09e667 bb67ae85 3c6ef372 a54ff53a 510e527f 9b05688c 1f83d9ab 5be0cd19 61626380 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000018 ba7816bf 8f01cfea 414140de 5dae2223 b00361a3 96177a9c b410ff61 f20015ad
empty 6a09e667 bb67ae85 3c6ef372 a54ff53a 510e527f 9b05688c 1f83d9ab 5be0cd19 80000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 e3b0c442 98fc1c14 9afbf4c8 996fb924 27ae41e4 649b934c a495991b 7852b855
two_blk_1 6a09e667 bb67ae85 3c6ef372 a54ff53a 510e527f 9b05688c 1f83d9ab 5be0cd19 61626364 62636465 63646566 64656667 65666768 66676869 6768696a 68696a6b 696a6b6c 6a6b6c6d 6b6c6d6e 6c6d6e6f 6d6e6f70 6e6f7071 80000000 00000000 85e655d6 417a1795 3363376a 624cde5c 76e09589 cac5f811 cc4b32c1 f20e533a
two_blk_2 85e655d6 417a1795 3363376a 624cde5c 76e09589 cac5f811 cc4b32c1 f20e533a 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 000001c0 248d6a61 d20638b8 e5c02693 0c3e6039 a33ce459 64ff2167 f6ecedd4 19db06c1
